// ==== logic/neoled_pkg.sv ====
// smart-LED transmitter shared definitions
// control word layout, field widths, FIFO depth, LED data word views,
// FIFO entry format and serial engine states
package neoled_pkg;

    // control word bit positions --------------------
    localparam int ctrl_en_c         = 0;  // r/w module enable
    localparam int ctrl_mode_c       = 1;  // r/w 0 = RGB 24 bit, 1 = RGBW 32 bit
    localparam int ctrl_strobe_c     = 2;  // r/w tag next data writes as strobe
    localparam int ctrl_clksel_lsb_c = 3;  // r/w prescaler select, 3 bits
    localparam int ctrl_bufs_lsb_c   = 6;  // r/- log2 of FIFO depth, 4 bits
    localparam int ctrl_t_tot_lsb_c  = 10; // r/w ticks per bit period
    localparam int ctrl_t_0h_lsb_c   = 15; // r/w ticks high for a zero
    localparam int ctrl_t_1h_lsb_c   = 20; // r/w ticks high for a one
    localparam int ctrl_irq_conf_c   = 27; // r/w irq condition select
    localparam int ctrl_tx_empty_c   = 28; // r/- FIFO empty
    localparam int ctrl_tx_half_c    = 29; // r/- FIFO at least half full
    localparam int ctrl_tx_full_c    = 30; // r/- FIFO full
    localparam int ctrl_tx_busy_c    = 31; // r/- engine busy

    // field widths and sizes ------------------------
    localparam int clksel_w_c       = 3;
    localparam int timing_w_c       = 5;
    localparam int bufs_w_c         = 4;
    localparam int tx_fifo_depth_c  = 4;   // power of two
    localparam int strobe_periods_c = 127; // low periods per strobe

    localparam int addr_ctrl_c = 0; // word offsets
    localparam int addr_data_c = 1;

    // one LED data word, seen as RGBW or RGB
    typedef union packed {
        struct packed {
            logic [7:0] w;
            logic [7:0] r;
            logic [7:0] g;
            logic [7:0] b;
        } rgbw;
        struct packed {
            logic [7:0] unused; // not sent in RGB mode
            logic [7:0] g;
            logic [7:0] r;
            logic [7:0] b;
        } rgb;
    } led_word_u;

    typedef struct packed {
        logic      strobe; // send strobe instead of data
        logic      mode;   // RGBW when set
        led_word_u data;
    } tx_entry_t;

    typedef enum logic [2:0] {S_IDLE, S_INIT, S_GETBIT, S_PULSE, S_STROBE} serial_state_t;

endpackage

// ==== logic/neoled_if.sv ====
// configuration and status bundles of the smart-LED transmitter
// cfg carries the control register fields as levels
// status carries the FIFO flags and the engine busy flag
`timescale 1ns/1ns

interface neoled_cfg_if;
    import neoled_pkg::*;

    logic                  enable;   // module on
    logic                  mode;     // RGBW when set
    logic                  strobe;   // tag writes as strobe
    logic [clksel_w_c-1:0] clk_prsc; // tick every 2^(n+1) clocks
    logic                  irq_conf; // irq on less than half full
    logic [timing_w_c-1:0] t_total;  // period in ticks, minus one
    logic [timing_w_c-1:0] t0_high;  // zero high-time, minus one
    logic [timing_w_c-1:0] t1_high;  // one high-time, minus one

    modport source (
        output enable, mode, strobe, clk_prsc, irq_conf, t_total, t0_high, t1_high
    );
    modport sink (
        input enable, mode, strobe, clk_prsc, irq_conf, t_total, t0_high, t1_high
    );
endinterface

interface neoled_status_if;
    logic tx_empty; // from FIFO
    logic tx_half;
    logic tx_full;
    logic tx_busy;  // from engine

    modport fifo (
        output tx_empty, tx_half, tx_full
    );
    modport engine (
        output tx_busy
    );
    modport reader (
        input tx_empty, tx_half, tx_full, tx_busy
    );
endinterface

// ==== logic/neoled_reg_decode.sv ====
// bus write decode of the smart-LED transmitter
// offset 0 loads the control register, offset 1 queues a FIFO entry
// tagged with the current strobe and mode bits
`timescale 1ns/1ns

module neoled_reg_decode (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  addr_i,       // word offset
    input  logic                  wren_i,
    input  logic [31:0]           data_i,
    neoled_cfg_if.source          cfg,
    output logic                  fifo_we_o,
    output neoled_pkg::tx_entry_t fifo_wdata_o
);
    import neoled_pkg::*;

    logic ctrl_we; // control register write
    logic data_we; // data word write

    assign ctrl_we = wren_i & (addr_i == 1'(addr_ctrl_c));
    assign data_we = wren_i & (addr_i == 1'(addr_data_c));

    // control register ------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg.enable   <= 1'b0;
            cfg.mode     <= 1'b0;
            cfg.strobe   <= 1'b0;
            cfg.clk_prsc <= '0;
            cfg.irq_conf <= 1'b0;
            cfg.t_total  <= '0;
            cfg.t0_high  <= '0;
            cfg.t1_high  <= '0;
        end else if (ctrl_we) begin
            cfg.enable   <= data_i[ctrl_en_c];
            cfg.mode     <= data_i[ctrl_mode_c];
            cfg.strobe   <= data_i[ctrl_strobe_c];
            cfg.clk_prsc <= data_i[ctrl_clksel_lsb_c +: clksel_w_c];
            cfg.irq_conf <= data_i[ctrl_irq_conf_c];
            cfg.t_total  <= data_i[ctrl_t_tot_lsb_c +: timing_w_c];
            cfg.t0_high  <= data_i[ctrl_t_0h_lsb_c +: timing_w_c];
            cfg.t1_high  <= data_i[ctrl_t_1h_lsb_c +: timing_w_c];
        end
    end

    // FIFO write request ----------------------------
    // the FIFO takes the entry on the same edge as the bus write
    assign fifo_we_o           = data_we;
    assign fifo_wdata_o.strobe = cfg.strobe; // tag from current control bits
    assign fifo_wdata_o.mode   = cfg.mode;
    assign fifo_wdata_o.data   = data_i;     // raw word, decoded by engine

endmodule

// ==== logic/neoled_tx_fifo.sv ====
// TX FIFO of the smart-LED transmitter
// circular buffer with one extra pointer bit for full/empty,
// registered read data, synchronous clear and empty/half/full flags
`timescale 1ns/1ns

module neoled_tx_fifo #(
    parameter int depth = neoled_pkg::tx_fifo_depth_c // power of two
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  clear_i, // sync flush
    input  logic                  we_i,
    input  logic                  re_i,
    input  neoled_pkg::tx_entry_t wdata_i,
    output neoled_pkg::tx_entry_t rdata_o, // valid one clock after a read
    output logic                  avail_o,
    neoled_status_if.fifo         status
);
    import neoled_pkg::*;

    localparam int aw_c = $clog2(depth);
    localparam logic [aw_c:0] half_c = (aw_c + 1)'(depth / 2);

    tx_entry_t     mem [0:depth-1]; // storage, no reset
    logic [aw_c:0] wr_ptr;          // msb is the wrap bit
    logic [aw_c:0] rd_ptr;
    logic [aw_c:0] level;           // entries held
    logic          full;
    logic          empty;
    logic          do_write;
    logic          do_read;

    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[aw_c] != rd_ptr[aw_c]) &&
                      (wr_ptr[aw_c-1:0] == rd_ptr[aw_c-1:0]);
    assign level    = wr_ptr - rd_ptr;
    assign do_write = we_i & ~full;  // drop writes when full
    assign do_read  = re_i & ~empty; // ignore reads when empty

    // pointers --------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage and registered read -------------------
    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_ptr[aw_c-1:0]] <= wdata_i;
        end
        if (do_read) begin
            rdata_o <= mem[rd_ptr[aw_c-1:0]];
        end
    end

    assign avail_o         = ~empty;
    assign status.tx_empty = empty;
    assign status.tx_full  = full;
    assign status.tx_half  = (level >= half_c); // at least half full

endmodule

// ==== logic/neoled_serial_engine.sv ====
// serial pulse engine of the smart-LED transmitter
// prescaler tick, MSB-first bit FSM with programmable period and
// high-times, and the long low period of the strobe command
`timescale 1ns/1ns

module neoled_serial_engine (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    neoled_cfg_if.sink            cfg,
    input  neoled_pkg::tx_entry_t entry_i, // FIFO read data
    input  logic                  avail_i,
    output logic                  fifo_re_o,
    neoled_status_if.engine       status,
    output logic                  neoled_o
);
    import neoled_pkg::*;

    localparam int strobe_w_c = $clog2(strobe_periods_c + 1);

    serial_state_t         state;
    logic [7:0]            prsc_cnt;   // free-running prescaler
    logic [7:0]            prsc_mask;  // low bits that must be all ones
    logic                  tick;       // one clock per prescaler period
    logic [5:0]            bit_cnt;    // bits left in frame
    logic [timing_w_c-1:0] pulse_cnt;  // ticks into current period
    logic [strobe_w_c-1:0] strobe_cnt; // low periods done in strobe
    logic                  tx_out;
    led_word_u             sreg;       // shift register, payload
    logic                  mode_q;     // RGBW frame when set
    logic [timing_w_c-1:0] t_high;     // high-time of current bit
    logic                  next_bit;

    assign prsc_mask = 8'((9'd2 << cfg.clk_prsc) - 9'd1);

    // first bit sits at the top of the view that matches the mode
    assign next_bit = mode_q ? sreg.rgbw.w[7] : sreg.rgb.g[7];

    // control FSM -----------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state      <= S_IDLE;
            prsc_cnt   <= '0;
            tick       <= 1'b0;
            bit_cnt    <= '0;
            pulse_cnt  <= '0;
            strobe_cnt <= '0;
            tx_out     <= 1'b0;
        end else if (!cfg.enable) begin // disabled, park in idle
            state    <= S_IDLE;
            prsc_cnt <= '0;
            tick     <= 1'b0;
            tx_out   <= 1'b0;
        end else begin
            prsc_cnt <= prsc_cnt + 8'd1;
            tick     <= ((prsc_cnt & prsc_mask) == prsc_mask);
            unique case (state)
                S_IDLE: begin
                    tx_out     <= 1'b0;
                    pulse_cnt  <= '0;
                    strobe_cnt <= '0;
                    if (avail_i) begin
                        state <= S_INIT; // read data valid next clock
                    end
                end
                S_INIT: begin
                    bit_cnt <= entry_i.mode ? 6'd32 : 6'd24;
                    state   <= entry_i.strobe ? S_STROBE : S_GETBIT;
                end
                S_GETBIT: begin
                    bit_cnt   <= bit_cnt - 6'd1;
                    pulse_cnt <= '0;
                    if (bit_cnt == 6'd0) begin // frame done
                        tx_out <= 1'b0;
                        state  <= S_IDLE;
                    end else begin
                        tx_out <= 1'b1; // start of bit period
                        state  <= S_PULSE;
                    end
                end
                S_PULSE: begin
                    if (tick) begin
                        pulse_cnt <= pulse_cnt + 1'b1;
                        if (pulse_cnt == t_high) begin
                            tx_out <= 1'b0; // end of high-time
                        end
                        if (pulse_cnt == cfg.t_total) begin
                            state <= S_GETBIT;
                        end
                    end
                end
                S_STROBE: begin // line stays low
                    if (tick) begin
                        if (pulse_cnt == cfg.t_total) begin
                            pulse_cnt  <= '0;
                            strobe_cnt <= strobe_cnt + 1'b1;
                        end else begin
                            pulse_cnt <= pulse_cnt + 1'b1;
                        end
                    end
                    if (strobe_cnt == strobe_w_c'(strobe_periods_c)) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // shift register and per-bit high-time ----------
    always_ff @(posedge clk_i) begin
        if (state == S_INIT) begin
            mode_q <= entry_i.mode;
            sreg   <= entry_i.data;
        end else if (state == S_GETBIT) begin
            sreg   <= {sreg[30:0], 1'b0}; // msb first
            t_high <= next_bit ? cfg.t1_high : cfg.t0_high;
        end
    end

    assign fifo_re_o      = (state == S_IDLE); // pull while idle
    assign status.tx_busy = (state != S_IDLE);
    assign neoled_o       = tx_out & cfg.enable; // low at once when disabled

endmodule

// ==== logic/neoled_status.sv ====
// readback, acknowledge and interrupt of the smart-LED transmitter
// assembles the control word with FIFO size and status flags
`timescale 1ns/1ns

module neoled_status (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              rden_i,
    input  logic              wren_i,
    input  logic              addr_i,
    neoled_cfg_if.sink        cfg,
    neoled_status_if.reader   status,
    output logic [31:0]       data_o,
    output logic              ack_o,
    output logic              irq_o
);
    import neoled_pkg::*;

    localparam logic [bufs_w_c-1:0] bufs_c = bufs_w_c'($clog2(tx_fifo_depth_c));

    logic ctrl_rd; // read of control offset

    assign ctrl_rd = rden_i & (addr_i == 1'(addr_ctrl_c));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_o  <= 1'b0;
            irq_o  <= 1'b0;
            data_o <= '0;
        end else begin
            ack_o  <= rden_i | wren_i; // one cycle after any access
            data_o <= '0;              // zero unless control read
            if (ctrl_rd) begin
                data_o[ctrl_en_c]                          <= cfg.enable;
                data_o[ctrl_mode_c]                        <= cfg.mode;
                data_o[ctrl_strobe_c]                      <= cfg.strobe;
                data_o[ctrl_clksel_lsb_c +: clksel_w_c]    <= cfg.clk_prsc;
                data_o[ctrl_bufs_lsb_c +: bufs_w_c]        <= bufs_c;
                data_o[ctrl_t_tot_lsb_c +: timing_w_c]     <= cfg.t_total;
                data_o[ctrl_t_0h_lsb_c +: timing_w_c]      <= cfg.t0_high;
                data_o[ctrl_t_1h_lsb_c +: timing_w_c]      <= cfg.t1_high;
                data_o[ctrl_irq_conf_c]                    <= cfg.irq_conf;
                data_o[ctrl_tx_empty_c]                    <= status.tx_empty;
                data_o[ctrl_tx_half_c]                     <= status.tx_half;
                data_o[ctrl_tx_full_c]                     <= status.tx_full;
                data_o[ctrl_tx_busy_c]                     <= status.tx_busy;
            end
            // irq only while enabled
            irq_o <= cfg.enable & ((~cfg.irq_conf & status.tx_empty) | // drained
                                   ( cfg.irq_conf & ~status.tx_half)); // below half
        end
    end

endmodule

// ==== logic/neoled_top.sv ====
// smart-LED serial transmitter, top level
// word bus with control at offset 0 and data at offset 1,
// TX FIFO feeding the serial engine, one serial line and an irq
`timescale 1ns/1ns

module neoled_top (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        addr_i,  // word offset
    input  logic        rden_i,
    input  logic        wren_i,
    input  logic [31:0] data_i,
    output logic [31:0] data_o,
    output logic        ack_o,
    output logic        irq_o,
    output logic        neoled_o // serial LED line
);
    import neoled_pkg::*;

    neoled_cfg_if    cfg_if ();
    neoled_status_if status_if ();

    logic      fifo_we;
    logic      fifo_re;
    logic      fifo_avail;
    logic      fifo_clear;
    tx_entry_t fifo_wdata;
    tx_entry_t fifo_rdata;

    assign fifo_clear = ~cfg_if.enable; // flush while disabled

    neoled_reg_decode u_decode (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .addr_i       (addr_i),
        .wren_i       (wren_i),
        .data_i       (data_i),
        .cfg          (cfg_if.source),
        .fifo_we_o    (fifo_we),
        .fifo_wdata_o (fifo_wdata)
    );

    neoled_tx_fifo #(
        .depth (tx_fifo_depth_c)
    ) u_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .clear_i (fifo_clear),
        .we_i    (fifo_we),
        .re_i    (fifo_re),
        .wdata_i (fifo_wdata),
        .rdata_o (fifo_rdata),
        .avail_o (fifo_avail),
        .status  (status_if.fifo)
    );

    neoled_serial_engine u_engine (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .cfg       (cfg_if.sink),
        .entry_i   (fifo_rdata),
        .avail_i   (fifo_avail),
        .fifo_re_o (fifo_re),
        .status    (status_if.engine),
        .neoled_o  (neoled_o)
    );

    neoled_status u_status (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .rden_i (rden_i),
        .wren_i (wren_i),
        .addr_i (addr_i),
        .cfg    (cfg_if.sink),
        .status (status_if.reader),
        .data_o (data_o),
        .ack_o  (ack_o),
        .irq_o  (irq_o)
    );

endmodule

// ==== test/neoled_assertions.sv ====
// protocol and safety properties of the smart-LED transmitter
// bound to the top level, watches the bus acknowledge, the serial
// line, the FIFO flags and the interrupt
`timescale 1ns/1ns

module neoled_assertions (
    input logic                      clk_i,
    input logic                      rstn_i,
    input logic                      rden_i,
    input logic                      wren_i,
    input logic                      ack_i,
    input logic                      irq_i,
    input logic                      neoled_i,
    input logic                      enable_i,
    input logic                      tx_empty_i,
    input logic                      tx_full_i,
    input neoled_pkg::serial_state_t state_i
);
    import neoled_pkg::*;

    line_low_disabled: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !enable_i |-> !neoled_i) else $error("serial line high while disabled");

    ack_after_access: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (rden_i || wren_i) |=> ack_i) else $error("no acknowledge one cycle after access");

    ack_only_after_access: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(rden_i || wren_i) |=> !ack_i) else $error("acknowledge without access");

    fifo_flags_exclusive: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(tx_empty_i && tx_full_i)) else $error("FIFO empty and full together");

    irq_low_disabled: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !enable_i |=> !irq_i) else $error("interrupt high while disabled"); // irq is registered

    strobe_line_low: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_i == S_STROBE) |-> !neoled_i) else $error("serial line high during strobe");

endmodule

// ==== test/tb_neoled.sv ====
// testbench for the smart-LED serial transmitter
// table-driven bus writes and readbacks, a serial line decoder that
// turns high pulses back into bits, FIFO/irq checks and a cycle limit
`timescale 1ns/1ns

module tb_neoled;
    import neoled_pkg::*;

    // timing programmed into the DUT ----------------
    localparam int prsc_c         = 1;  // tick every 4 clocks
    localparam int t_total_c      = 7;
    localparam int t0_c           = 1;
    localparam int t1_c           = 4;
    localparam int tick_clks_c    = 2 << prsc_c;
    localparam int period_clks_c  = (t_total_c + 1) * tick_clks_c;
    localparam int threshold_c    = ((t0_c + 1) + (t1_c + 1)) * tick_clks_c / 2; // midpoint
    localparam int bufs_exp_c     = 2;  // log2 of a 4-deep FIFO
    localparam logic [31:0] status_idle_c = (32'(bufs_exp_c) << ctrl_bufs_lsb_c) |
                                            (32'd1 << ctrl_tx_empty_c);
    localparam logic [31:0] status_full_c = (32'(bufs_exp_c) << ctrl_bufs_lsb_c) |
                                            (32'd1 << ctrl_tx_half_c) |
                                            (32'd1 << ctrl_tx_full_c) |
                                            (32'd1 << ctrl_tx_busy_c); // four queued, one sending
    localparam int op_cfg_c       = 0;
    localparam int op_frame_c     = 1;
    localparam int op_strobe_c    = 2;
    localparam int n_rows_c       = 8;
    localparam int fifo_words_c   = 5;
    localparam int flush_words_c  = 3;
    localparam int row_overhead_c = 32; // bus and polling cycles per step

    logic        clk;
    logic        rstn;
    logic        addr;
    logic        rden;
    logic        wren;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        ack;
    logic        irq;
    logic        led;

    // stimulus table --------------------------------
    string       row_name [n_rows_c] = '{"cfg_rgb", "rgb_0", "rgb_1", "cfg_rgbw",
                                         "rgbw_0", "rgbw_1", "cfg_strobe", "strobe_0"};
    int          row_op   [n_rows_c] = '{op_cfg_c, op_frame_c, op_frame_c, op_cfg_c,
                                         op_frame_c, op_frame_c, op_cfg_c, op_strobe_c};
    logic        row_mode [n_rows_c] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
    logic        row_strb [n_rows_c] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    logic        row_irqc [n_rows_c] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
    int          row_bits [n_rows_c] = '{0, 24, 24, 0, 32, 32, 0, 0}; // expected pulses
    logic [31:0] row_data [n_rows_c]; // filled at start

    logic [31:0] lfsr_q      = 32'd66;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    int          hi_len      = 0; // clocks of current high pulse
    int          rx_count    = 0; // pulses seen so far
    logic [31:0] rx_bits     = '0; // last decoded bits, newest at lsb

    neoled_top dut_i (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .addr_i   (addr),
        .rden_i   (rden),
        .wren_i   (wren),
        .data_i   (wdata),
        .data_o   (rdata),
        .ack_o    (ack),
        .irq_o    (irq),
        .neoled_o (led)
    );

    bind neoled_top neoled_assertions u_assertions (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rden_i     (rden_i),
        .wren_i     (wren_i),
        .ack_i      (ack_o),
        .irq_i      (irq_o),
        .neoled_i   (neoled_o),
        .enable_i   (cfg_if.enable),
        .tx_empty_i (status_if.tx_empty),
        .tx_full_i  (status_if.tx_full),
        .state_i    (u_engine.state)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // line decoder, long pulse is a one
    always @(posedge clk) begin
        if (led) begin
            hi_len <= hi_len + 1;
        end else if (hi_len != 0) begin
            rx_bits  <= {rx_bits[30:0], (hi_len > threshold_c)};
            rx_count <= rx_count + 1;
            hi_len   <= 0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
    endfunction

    task automatic draw_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w      = {w[30:0], lfsr_q[0]}; // one step per bit
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    function automatic logic [31:0] make_ctrl(input logic en, input logic mode,
                                              input logic strb, input logic irq_conf);
        logic [31:0] w;
        w = '0;
        w[ctrl_en_c]                         = en;
        w[ctrl_mode_c]                       = mode;
        w[ctrl_strobe_c]                     = strb;
        w[ctrl_clksel_lsb_c +: clksel_w_c]   = clksel_w_c'(prsc_c);
        w[ctrl_t_tot_lsb_c +: timing_w_c]    = timing_w_c'(t_total_c);
        w[ctrl_t_0h_lsb_c +: timing_w_c]     = timing_w_c'(t0_c);
        w[ctrl_t_1h_lsb_c +: timing_w_c]     = timing_w_c'(t1_c);
        w[ctrl_irq_conf_c]                   = irq_conf;
        return w;
    endfunction

    function automatic logic [31:0] bit_mask(input int n);
        return (n >= 32) ? 32'hffff_ffff : ((32'd1 << n) - 32'd1);
    endfunction

    // twice the nominal length of all steps
    function automatic int calc_limit();
        int sum;
        sum = 10 + 8 * row_overhead_c; // reset and FIFO test accesses
        for (int i = 0; i < n_rows_c; i++) begin
            sum += row_bits[i] * period_clks_c + row_overhead_c;
            if (row_op[i] == op_strobe_c) begin
                sum += strobe_periods_c * period_clks_c;
            end
        end
        sum += (fifo_words_c + flush_words_c) * 24 * period_clks_c;
        return 2 * sum;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // bus access ------------------------------------
    task automatic wait_ack();
        @(posedge clk);
        while (!ack) @(posedge clk);
    endtask

    task automatic bus_write(input logic a, input logic [31:0] d);
        @(posedge clk);
        addr  <= a;
        wdata <= d;
        wren  <= 1'b1;
        @(posedge clk);
        wren <= 1'b0;
        wait_ack();
    endtask

    task automatic bus_read(input logic a, output logic [31:0] d);
        @(posedge clk);
        addr <= a;
        rden <= 1'b1;
        @(posedge clk);
        rden <= 1'b0;
        wait_ack();
        d = rdata;
    endtask

    // engine idle and nothing left queued
    task automatic wait_idle();
        logic [31:0] rd;
        rd = 32'hffff_ffff;
        while (rd[ctrl_tx_busy_c] || !rd[ctrl_tx_empty_c]) bus_read(1'(addr_ctrl_c), rd);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] word;
        int          start_cyc;
        int          start_rx;
        rstn        = 1'b0;
        addr        = 1'b0;
        rden        = 1'b0;
        wren        = 1'b0;
        wdata       = '0;
        cycle_limit = calc_limit();
        for (int i = 0; i < n_rows_c; i++) begin
            if (row_op[i] == op_cfg_c) begin
                row_data[i] = make_ctrl(1'b1, row_mode[i], row_strb[i], row_irqc[i]);
            end else begin
                draw_word(row_data[i]);
            end
        end
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        // reset state
        check_value("reset line", 32'd0, 32'(led));
        check_value("reset irq", 32'd0, 32'(irq));
        check_value("reset ack", 32'd0, 32'(ack));
        check_value("reset data", 32'd0, rdata);
        bus_read(1'(addr_ctrl_c), rd);
        check_value("reset ctrl", status_idle_c, rd);

        for (int i = 0; i < n_rows_c; i++) begin
            start_cyc = cycle_cnt;
            start_rx  = rx_count;
            case (row_op[i])
                op_cfg_c: begin
                    bus_write(1'(addr_ctrl_c), row_data[i]);
                    bus_read(1'(addr_ctrl_c), rd);
                    check_value(row_name[i], row_data[i] | status_idle_c, rd);
                end
                op_frame_c: begin
                    bus_write(1'(addr_data_c), row_data[i]);
                    wait_idle();
                    check_value({row_name[i], " pulses"}, 32'(row_bits[i]),
                                32'(rx_count - start_rx));
                    check_value({row_name[i], " bits"}, row_data[i] & bit_mask(row_bits[i]),
                                rx_bits & bit_mask(row_bits[i]));
                end
                default: begin // strobe, long low time and no pulse
                    bus_write(1'(addr_data_c), row_data[i]);
                    wait_idle();
                    check_value({row_name[i], " pulses"}, 32'd0, 32'(rx_count - start_rx));
                    check_value({row_name[i], " low time"}, 32'd1,
                                32'((cycle_cnt - start_cyc) >= strobe_periods_c * period_clks_c));
                    check_value({row_name[i], " line"}, 32'd0, 32'(led));
                end
            endcase
        end

        // FIFO fill, drain and flush -----------------
        bus_write(1'(addr_ctrl_c), make_ctrl(1'b1, 1'b0, 1'b0, 1'b0));
        bus_read(1'(addr_ctrl_c), rd);
        check_value("irq while empty", 32'd1, 32'(irq));
        start_rx = rx_count;
        word     = '0;
        for (int i = 0; i < fifo_words_c; i++) begin
            draw_word(word);
            bus_write(1'(addr_data_c), word);
        end
        bus_read(1'(addr_ctrl_c), rd);
        check_value("fifo full", make_ctrl(1'b1, 1'b0, 1'b0, 1'b0) | status_full_c, rd);
        check_value("irq while full", 32'd0, 32'(irq));
        wait_idle();
        check_value("fifo pulses", 32'(fifo_words_c * 24), 32'(rx_count - start_rx));
        check_value("fifo last frame", word & bit_mask(24), rx_bits & bit_mask(24));
        check_value("irq after drain", 32'd1, 32'(irq));
        for (int i = 0; i < flush_words_c; i++) begin
            draw_word(word);
            bus_write(1'(addr_data_c), word);
        end
        bus_write(1'(addr_ctrl_c), make_ctrl(1'b0, 1'b0, 1'b0, 1'b0));
        bus_read(1'(addr_ctrl_c), rd);
        check_value("flush ctrl", make_ctrl(1'b0, 1'b0, 1'b0, 1'b0) | status_idle_c, rd);
        check_value("irq disabled", 32'd0, 32'(irq));
        check_value("line disabled", 32'd0, 32'(led));

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
logic/neoled_pkg.sv
logic/neoled_if.sv
logic/neoled_reg_decode.sv
logic/neoled_tx_fifo.sv
logic/neoled_serial_engine.sv
logic/neoled_status.sv
logic/neoled_top.sv
test/neoled_assertions.sv
test/tb_neoled.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_neoled
RTL_TOP   ?= neoled_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
LINTFLAGS ?= --lint-only -Wall --timescale 1ns/1ns
RTL_SRCS  ?= logic/neoled_pkg.sv logic/neoled_if.sv logic/neoled_reg_decode.sv \
             logic/neoled_tx_fifo.sv logic/neoled_serial_engine.sv \
             logic/neoled_status.sv logic/neoled_top.sv

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
